// File: design/readReorderPkg.sv
// Read reorder unit shared definitions
// Widths, the tag type and the packed structs that carry commands,
// memory requests, memory responses and ordered results between blocks
package readReorderPkg;

    // Width of one read address
    localparam int ADDR_BITS = 32;

    // Width of the data returned by one read
    localparam int DATA_BITS = 64;

    // Width of the tag field on memory traffic
    // This caps the scoreboard depth at 64 slots
    localparam int MAX_TAG_BITS = 6;

    typedef logic [ADDR_BITS-1:0] t_addr;
    typedef logic [DATA_BITS-1:0] t_data;
    typedef logic [MAX_TAG_BITS-1:0] t_tag;

    // Default client meta, carried untouched from command to result
    typedef logic [7:0] t_meta;

    // Read command from a client
    typedef struct packed {
        t_addr addr;
        t_meta meta;
    } readCmd;

    // Request sent to memory, tagged with the reorder slot index
    typedef struct packed {
        t_addr addr;
        t_tag  tag;
    } memReq;

    // Response from memory, which may arrive in any order
    typedef struct packed {
        t_tag  tag;
        t_data data;
    } memRsp;

    // Ordered result handed to the consumer
    // Data comes from memory and meta from the original command
    typedef struct packed {
        t_data data;
        t_meta meta;
    } readResult;

endpackage

// File: design/creditCounter.sv
// Credit counter
// Holds a pool of credits loaded at reset, spent one at a time on issue
// and refilled one at a time on credit return
`timescale 1ns/1ps

module creditCounter
#(
    parameter int InitCredits = 8
)
(
    input  logic clk,
    input  logic resetb,
    input  logic spend,
    input  logic refill,
    output logic hasCredit
);

    // One spare bit keeps the count wide enough even for a zero pool
    localparam int CountBits = $clog2(InitCredits + 1) + 1;

    logic [CountBits-1:0] count;
    logic [CountBits-1:0] countNext;

    // A spend and a refill in the same cycle cancel out
    always_comb
    begin
        countNext = count;
        if (spend && !refill)
            countNext = count - CountBits'(1);
        else if (refill && !spend)
            countNext = count + CountBits'(1);
    end

    // hasCredit is taken from the next count so that it is a flop output
    // and still tracks the count with no extra cycle of lag
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            count     <= CountBits'(InitCredits);
            hasCredit <= (InitCredits != 0);
        end
        else
        begin
            count     <= countNext;
            hasCredit <= (countNext != '0);
        end
    end

endmodule

// File: design/readReqFsm.sv
// Read request state machine
// Accepts client read commands, allocates a reorder slot for each one and
// issues a memory request tagged with the slot index when both a free slot
// and a memory credit are present
`timescale 1ns/1ps

module readReqFsm
#(
    parameter int NumEntries = 16
)
(
    input  logic                   clk,
    input  logic                   resetb,

    input  logic                   cmdValid,
    input  readReorderPkg::readCmd cmd,
    output logic                   cmdReady,

    input  logic                   slotFree,
    input  readReorderPkg::t_tag   slotIdx,
    output logic                   alloc,
    output readReorderPkg::t_meta  allocMeta,

    input  logic                   credit,
    output logic                   spend,

    output logic                   memReqValid,
    output readReorderPkg::memReq  memReq
);

    import readReorderPkg::*;

    localparam int IdxBits = $clog2(NumEntries);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        STALL
    } t_state;

    t_state state;
    t_state stateNext;

    // Request captured at accept time, sent one cycle later
    readReorderPkg::memReq pendReq;

    logic haveRes;
    logic accept;

    // A command can only be taken with a free slot and a memory credit
    assign haveRes = slotFree && credit;

    assign cmdReady = (state == IDLE) && haveRes;
    assign accept   = cmdValid && cmdReady;

    // The slot is allocated in the accept cycle, so the meta goes straight in
    assign alloc     = accept;
    assign allocMeta = cmd.meta;

    // The credit is spent in the same cycle the request is registered
    assign spend = (state == ISSUE);

    always_comb
    begin
        stateNext = state;
        case (state)
            IDLE:
            begin
                if (accept)
                    stateNext = ISSUE;
                else if (!haveRes)
                    stateNext = STALL;
            end
            ISSUE:
            begin
                stateNext = IDLE;
            end
            STALL:
            begin
                // Wait here until a slot and a credit are both back
                if (haveRes)
                    stateNext = IDLE;
            end
            default:
            begin
                stateNext = STALL;
            end
        endcase
    end

    // Reset lands in STALL so cmdReady stays low for the first cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state       <= STALL;
            memReqValid <= 1'b0;
        end
        else
        begin
            state       <= stateNext;
            memReqValid <= (state == ISSUE);
        end
    end

    // The tag is the slot index folded to the scoreboard depth
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            pendReq.addr <= cmd.addr;
            pendReq.tag  <= t_tag'(slotIdx[IdxBits-1:0]);
        end
        if (state == ISSUE)
            memReq <= pendReq;
    end

endmodule

// File: design/reorderScoreboard.sv
// Reorder scoreboard
// A FIFO whose payload may be filled out of order. Meta is stored when a
// slot is allocated, data is stored when the late memory response comes
// back, and entries leave oldest first once their data is present
`timescale 1ns/1ps

module reorderScoreboard
#(
    parameter int  NumEntries = 16,
    parameter type MetaType   = readReorderPkg::t_meta
)
(
    input  logic                  clk,
    input  logic                  resetb,

    // Slot allocation, which returns the index of the new slot
    input  logic                  alloc,
    input  MetaType               allocMeta,
    output logic                  notFull,
    output readReorderPkg::t_tag  allocIdx,

    // Data fill from memory, always accepted
    input  logic                  fillValid,
    input  readReorderPkg::memRsp fill,

    // Ordered output
    input  logic                  deq,
    output logic                  notEmpty,
    output readReorderPkg::t_data first,
    output MetaType               firstMeta
);

    import readReorderPkg::*;

    localparam int IdxBits = $clog2(NumEntries);

    typedef logic [IdxBits-1:0] t_idx;

    // Pointers carry one wrap bit above the index so that all NumEntries
    // slots can be in use at once
    typedef logic [IdxBits:0] t_ptr;

    t_ptr newest;
    t_ptr oldest;
    t_ptr oldestNext;

    t_idx newestIdx;
    t_idx oldestIdx;
    t_idx readIdx;
    t_idx fillIdx;

    // One bit per slot, set when its data has arrived
    logic [NumEntries-1:0] filled;
    logic [NumEntries-1:0] filledNext;

    t_data   dataMem [NumEntries];
    MetaType metaMem [NumEntries];

    // Memory responses are registered once before they touch the arrays
    logic  fillValidQ;
    memRsp fillQ;

    assign newestIdx = newest[IdxBits-1:0];
    assign oldestIdx = oldest[IdxBits-1:0];
    assign readIdx   = oldestNext[IdxBits-1:0];
    assign fillIdx   = fillQ.tag[IdxBits-1:0];

    // Full when the indexes match but the wrap bits differ
    assign notFull = !((newest[IdxBits] != oldest[IdxBits]) && (newestIdx == oldestIdx));

    assign allocIdx = t_tag'(newestIdx);

    // The oldest pointer moves one slot on each dequeue
    assign oldestNext = oldest + t_ptr'(deq);

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest     <= '0;
            oldest     <= '0;
            fillValidQ <= 1'b0;
        end
        else
        begin
            if (alloc)
                newest <= newest + t_ptr'(1);
            oldest     <= oldestNext;
            fillValidQ <= fillValid;
        end
    end

    always_ff @(posedge clk)
    begin
        fillQ <= fill;
    end

    // Data array, written by the registered response and read ahead at
    // the slot that will be oldest in the next cycle
    always_ff @(posedge clk)
    begin
        if (fillValidQ)
            dataMem[fillIdx] <= fillQ.data;
        first <= dataMem[readIdx];
    end

    // Meta array, written at allocation time
    always_ff @(posedge clk)
    begin
        if (alloc)
            metaMem[newestIdx] <= allocMeta;
        firstMeta <= metaMem[readIdx];
    end

    // A dequeue frees the oldest slot and a fill marks its own slot
    always_comb
    begin
        filledNext = filled;
        if (deq)
            filledNext[oldestIdx] = 1'b0;
        if (fillValidQ)
            filledNext[fillIdx] = 1'b1;
    end

    // notEmpty is looked up the same way as first, with no bypass around
    // the arrays, so it rises in the first cycle first holds the right data
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            filled   <= '0;
            notEmpty <= 1'b0;
        end
        else
        begin
            filled   <= filledNext;
            notEmpty <= filled[readIdx];
        end
    end

endmodule

// File: design/resultStage.sv
// Result stage
// Takes the oldest completed scoreboard entry when a consumer credit is
// available and registers it as one result pulse
`timescale 1ns/1ps

module resultStage
(
    input  logic                      clk,
    input  logic                      resetb,

    input  logic                      notEmpty,
    input  readReorderPkg::t_data     first,
    input  readReorderPkg::t_meta     firstMeta,

    input  logic                      credit,

    output logic                      deq,
    output logic                      spend,

    output logic                      resultValid,
    output readReorderPkg::readResult result
);

    import readReorderPkg::*;

    readResult resultNext;

    // Dequeue and credit spend always happen as a pair
    assign deq   = notEmpty && credit;
    assign spend = deq;

    // Join the returned data with the meta stored at allocation
    assign resultNext.data = first;
    assign resultNext.meta = firstMeta;

    always_ff @(posedge clk)
    begin
        if (!resetb)
            resultValid <= 1'b0;
        else
            resultValid <= deq;
    end

    always_ff @(posedge clk)
    begin
        if (deq)
            result <= resultNext;
    end

endmodule

// File: design/readReorderTop.sv
// Read reorder unit
// Issues tagged memory reads for client commands and returns the results
// in command order, using credit flow control toward memory and toward
// the consumer
`timescale 1ns/1ps

module readReorderTop
#(
    parameter int NumEntries = 16,
    parameter int MemCredits = 8,
    parameter int OutCredits = 4
)
(
    input  logic                      clk,
    input  logic                      resetb,

    // Command input
    input  logic                      cmdValid,
    input  readReorderPkg::readCmd    cmd,
    output logic                      cmdReady,

    // Memory request and response
    output logic                      memReqValid,
    output readReorderPkg::memReq     memReq,
    input  logic                      memRspValid,
    input  readReorderPkg::memRsp     memRsp,
    input  logic                      memCreditReturn,

    // Ordered results
    output logic                      resultValid,
    output readReorderPkg::readResult result,
    input  logic                      outCreditReturn
);

    import readReorderPkg::*;

    // Slot allocation between the FSM and the scoreboard
    logic  slotFree;
    t_tag  allocIdx;
    logic  alloc;
    t_meta allocMeta;

    // Credit counter links
    logic  memCredit;
    logic  memSpend;
    logic  outCredit;
    logic  outSpend;

    // Scoreboard output toward the result stage
    logic  sbNotEmpty;
    t_data sbFirst;
    t_meta sbFirstMeta;
    logic  deq;

    readReqFsm #(
        .NumEntries (NumEntries)
    ) reqFsm_i (
        .clk         (clk),
        .resetb      (resetb),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .cmdReady    (cmdReady),
        .slotFree    (slotFree),
        .slotIdx     (allocIdx),
        .alloc       (alloc),
        .allocMeta   (allocMeta),
        .credit      (memCredit),
        .spend       (memSpend),
        .memReqValid (memReqValid),
        .memReq      (memReq)
    );

    // Credits toward memory, one per outstanding request
    creditCounter #(
        .InitCredits (MemCredits)
    ) memCredit_i (
        .clk       (clk),
        .resetb    (resetb),
        .spend     (memSpend),
        .refill    (memCreditReturn),
        .hasCredit (memCredit)
    );

    // Credits toward the consumer, one per result it can take
    creditCounter #(
        .InitCredits (OutCredits)
    ) outCredit_i (
        .clk       (clk),
        .resetb    (resetb),
        .spend     (outSpend),
        .refill    (outCreditReturn),
        .hasCredit (outCredit)
    );

    reorderScoreboard #(
        .NumEntries (NumEntries),
        .MetaType   (t_meta)
    ) scoreboard_i (
        .clk       (clk),
        .resetb    (resetb),
        .alloc     (alloc),
        .allocMeta (allocMeta),
        .notFull   (slotFree),
        .allocIdx  (allocIdx),
        .fillValid (memRspValid),
        .fill      (memRsp),
        .deq       (deq),
        .notEmpty  (sbNotEmpty),
        .first     (sbFirst),
        .firstMeta (sbFirstMeta)
    );

    resultStage resultStage_i (
        .clk         (clk),
        .resetb      (resetb),
        .notEmpty    (sbNotEmpty),
        .first       (sbFirst),
        .firstMeta   (sbFirstMeta),
        .credit      (outCredit),
        .deq         (deq),
        .spend       (outSpend),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

// File: verif/readReorderTb.sv
// Read reorder unit testbench
// Replays a trace of commands against a memory model that answers out of
// order and a consumer that returns credits late, then checks the ordered
// results, the request tags and the credit limits
`timescale 1ns/1ps

module readReorderTb;

    import readReorderPkg::*;

    localparam int NumEntries  = 16;
    localparam int MemCredits  = 8;
    localparam int OutCredits  = 4;
    localparam int MaxCmds     = 64;
    localparam int WaitLimit   = 3000;
    // The consumer holds its credits this long so the scoreboard fills up
    localparam int StallCycles = 200;

    logic      clk;
    logic      resetb;
    logic      cmdValid;
    readCmd    cmd;
    logic      cmdReady;
    logic      memReqValid;
    memReq     req;
    logic      memRspValid;
    memRsp     rsp;
    logic      memCreditReturn;
    logic      resultValid;
    readResult res;
    logic      outCreditReturn;

    // Trace contents
    readCmd    cmds    [MaxCmds];
    int        rspSeq  [MaxCmds];
    t_data     rspData [MaxCmds];
    readResult expRes  [MaxCmds];
    t_tag      issuedTag [MaxCmds];
    int        numCmds;
    int        numRsps;
    int        numExp;

    // Progress counters shared by the models and the monitor
    int acceptCount;
    int issueCount;
    int rspCount;
    int resultCount;
    int creditsReturned;

    int mismatchErrors;
    int timeoutErrors;
    int otherErrors;
    int seed;

    readReorderTop #(
        .NumEntries (NumEntries),
        .MemCredits (MemCredits),
        .OutCredits (OutCredits)
    ) dut_i (
        .clk             (clk),
        .resetb          (resetb),
        .cmdValid        (cmdValid),
        .cmd             (cmd),
        .cmdReady        (cmdReady),
        .memReqValid     (memReqValid),
        .memReq          (req),
        .memRspValid     (memRspValid),
        .memRsp          (rsp),
        .memCreditReturn (memCreditReturn),
        .resultValid     (resultValid),
        .result          (res),
        .outCreditReturn (outCreditReturn)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    task automatic compareReq(input memReq got, input memReq exp, input int idx);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: request %0d addr %h tag %0d, expected addr %h tag %0d",
                     $time, idx, got.addr, got.tag, exp.addr, exp.tag);
            mismatchErrors++;
        end
    endtask

    task automatic compareResult(input readResult got, input readResult exp, input int idx);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: result %0d data %h meta %h, expected data %h meta %h",
                     $time, idx, got.data, got.meta, exp.data, exp.meta);
            mismatchErrors++;
        end
    endtask

    // Lines are C addr meta, R seq data, or E data meta; # starts a comment
    task automatic loadTrace();
        int        fd;
        string     line;
        byte       kind;
        logic [63:0] a;
        logic [63:0] b;
        int        s;
        fd = $fopen("verif/readReorderTrace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2)
                continue;
            kind = line.getc(0);
            s = 3;
            if (kind == "C")
            begin
                s = $sscanf(line, "%c %h %h", kind, a, b);
                cmds[numCmds].addr = t_addr'(a);
                cmds[numCmds].meta = t_meta'(b);
                numCmds++;
            end
            else if (kind == "R")
            begin
                s = $sscanf(line, "%c %d %h", kind, rspSeq[numRsps], b);
                rspData[numRsps] = b;
                numRsps++;
            end
            else if (kind == "E")
            begin
                s = $sscanf(line, "%c %h %h", kind, a, b);
                expRes[numExp].data = a;
                expRes[numExp].meta = t_meta'(b);
                numExp++;
            end
            if (s != 3)
            begin
                $display("Could not parse trace line: %s", line);
                otherErrors++;
            end
        end
        $fclose(fd);
        if (numCmds != numRsps || numCmds != numExp)
        begin
            $display("Trace has %0d commands, %0d responses and %0d expected results",
                     numCmds, numRsps, numExp);
            otherErrors++;
        end
    endtask

    // Each command is held until the DUT takes it
    task automatic driveCommands();
        int  cycles;
        logic ready;
        @(posedge clk);
        for (int i = 0; i < numCmds; i++)
        begin
            cmdValid <= 1'b1;
            cmd      <= cmds[i];
            cycles = 0;
            ready  = 1'b0;
            while (!ready && cycles < WaitLimit)
            begin
                @(negedge clk);
                ready = cmdReady;
                cycles++;
            end
            if (!ready)
            begin
                $display("Timed out waiting for cmdReady on command %0d", i);
                timeoutErrors++;
                break;
            end
            @(posedge clk);
            acceptCount++;
        end
        cmdValid <= 1'b0;
    endtask

    // Answers R lines in trace order once the request has gone out
    task automatic answerMemory();
        int cycles;
        int s;
        for (int k = 0; k < numRsps; k++)
        begin
            s = rspSeq[k];
            cycles = 0;
            while (issueCount <= s && cycles < WaitLimit)
            begin
                @(negedge clk);
                cycles++;
            end
            if (issueCount <= s)
            begin
                $display("Timed out waiting for request %0d to reach memory", s);
                timeoutErrors++;
                break;
            end
            @(posedge clk);
            memRspValid     <= 1'b1;
            rsp.tag         <= issuedTag[s];
            rsp.data        <= rspData[k];
            memCreditReturn <= 1'b1;
            rspCount++;
            @(posedge clk);
            memRspValid     <= 1'b0;
            memCreditReturn <= 1'b0;
        end
    endtask

    // One credit back per result, after a random delay of 0 to 3 cycles
    task automatic returnCredits();
        int cycles;
        int delay;
        repeat (StallCycles) @(posedge clk);
        for (int i = 0; i < numCmds; i++)
        begin
            cycles = 0;
            while (resultCount <= i && cycles < WaitLimit)
            begin
                @(negedge clk);
                cycles++;
            end
            if (resultCount <= i)
            begin
                $display("Timed out waiting for result %0d at the consumer", i);
                timeoutErrors++;
                break;
            end
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            outCreditReturn <= 1'b1;
            creditsReturned++;
            @(posedge clk);
            outCreditReturn <= 1'b0;
        end
    endtask

    task automatic waitResults();
        int cycles;
        cycles = 0;
        while (resultCount < numCmds && cycles < 4 * WaitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (resultCount < numCmds)
        begin
            $display("Timed out with %0d of %0d results received", resultCount, numCmds);
            timeoutErrors++;
        end
        // Give a duplicate result time to show up
        repeat (10) @(negedge clk);
    endtask

    // Outputs are sampled at the falling edge, away from the DUT's updates
    always @(negedge clk)
    begin
        if (!resetb)
        begin
            if (memReqValid !== 1'b0 || resultValid !== 1'b0)
            begin
                $display("Output valid was not low during reset at %0t", $time);
                otherErrors++;
            end
        end
        else
        begin
            if (memReqValid)
            begin
                if (issueCount < numCmds)
                begin
                    compareReq(req, '{addr: cmds[issueCount].addr,
                                      tag: t_tag'(issueCount % NumEntries)}, issueCount);
                    issuedTag[issueCount] = req.tag;
                end
                else
                begin
                    $display("Extra memory request at %0t", $time);
                    otherErrors++;
                end
                issueCount++;
            end
            if (resultValid)
            begin
                if (resultCount < numCmds)
                    compareResult(res, expRes[resultCount], resultCount);
                else
                begin
                    $display("Extra result at %0t", $time);
                    otherErrors++;
                end
                resultCount++;
                if (resultCount > OutCredits + creditsReturned)
                begin
                    $display("Result %0d went out without a consumer credit", resultCount - 1);
                    otherErrors++;
                end
            end
            // Responses counted here reach the DUT's credit pool one edge later,
            // so this count never runs ahead of the credits really in use
            if (issueCount - rspCount >= MemCredits && cmdReady)
            begin
                $display("cmdReady was high with all %0d memory credits in use at %0t",
                         MemCredits, $time);
                otherErrors++;
            end
            // Every slot holds a read that has not left yet
            if (acceptCount - resultCount >= NumEntries && cmdReady)
            begin
                $display("cmdReady was high with %0d reads held in the scoreboard at %0t",
                         NumEntries, $time);
                otherErrors++;
            end
        end
    end

    initial
    begin
        seed            = 98102;
        numCmds         = 0;
        numRsps         = 0;
        numExp          = 0;
        acceptCount     = 0;
        issueCount      = 0;
        rspCount        = 0;
        resultCount     = 0;
        creditsReturned = 0;
        mismatchErrors  = 0;
        timeoutErrors   = 0;
        otherErrors     = 0;
        resetb          <= 1'b0;
        cmdValid        <= 1'b0;
        cmd             <= '0;
        memRspValid     <= 1'b0;
        rsp             <= '0;
        memCreditReturn <= 1'b0;
        outCreditReturn <= 1'b0;
        loadTrace();
        repeat (5) @(posedge clk);
        resetb <= 1'b1;
        if (otherErrors == 0)
        begin
            fork
                driveCommands();
                answerMemory();
                returnCredits();
                waitResults();
            join
        end
        $display("Errors: mismatches %0d, timeouts %0d, other %0d",
                 mismatchErrors, timeoutErrors, otherErrors);
        if (mismatchErrors == 0 && timeoutErrors == 0 && otherErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: verif/readReorderTrace.txt
# C address meta | R request sequence number and data, in memory response order
# E expected data and meta, in command order
C 00010000 50
C 00010040 51
C 00010080 52
C 000100c0 53
C 00010100 54
C 00010140 55
C 00010180 56
C 000101c0 57
C 00010200 58
C 00010240 59
C 00010280 5a
C 000102c0 5b
C 00010300 5c
C 00010340 5d
C 00010380 5e
C 000103c0 5f
C 00010400 60
C 00010440 61
C 00010480 62
C 000104c0 63
R 7 c0de000000001007
R 6 c0de000000001006
R 5 c0de000000001005
R 4 c0de000000001004
R 3 c0de000000001003
R 2 c0de000000001002
R 1 c0de000000001001
R 0 c0de000000001000
R 11 c0de00000000100b
R 9 c0de000000001009
R 8 c0de000000001008
R 10 c0de00000000100a
R 14 c0de00000000100e
R 12 c0de00000000100c
R 15 c0de00000000100f
R 13 c0de00000000100d
R 19 c0de000000001013
R 17 c0de000000001011
R 16 c0de000000001010
R 18 c0de000000001012
E c0de000000001000 50
E c0de000000001001 51
E c0de000000001002 52
E c0de000000001003 53
E c0de000000001004 54
E c0de000000001005 55
E c0de000000001006 56
E c0de000000001007 57
E c0de000000001008 58
E c0de000000001009 59
E c0de00000000100a 5a
E c0de00000000100b 5b
E c0de00000000100c 5c
E c0de00000000100d 5d
E c0de00000000100e 5e
E c0de00000000100f 5f
E c0de000000001010 60
E c0de000000001011 61
E c0de000000001012 62
E c0de000000001013 63

// File: build.f
design/readReorderPkg.sv
design/creditCounter.sv
design/readReqFsm.sv
design/reorderScoreboard.sv
design/resultStage.sv
design/readReorderTop.sv
verif/readReorderTb.sv

// File: run.sh
#!/bin/sh
# Compile the read reorder unit and its testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module readReorderTb -o readReorderSim

# The log decides the result, so a nonzero exit of the run is not fatal here
./obj_dir/readReorderSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
